// ==== Bender.yml ====
package:
  name: dcache

sources:
  - files:
      - rtl/dcache_pkg.sv
      - rtl/dcache_line_array.sv
      - rtl/dcache_miss_ctrl.sv
      - rtl/dcache_load_align.sv
      - rtl/dcache_top.sv
  - target: test
    files:
      - verif/dcache_mem_model.sv
      - verif/dcache_tb.sv

// ==== rtl/dcache_line_array.sv ====
`timescale 1ns/1ns

module dcache_line_array #(
    parameter int num_lines = 8
) (
    input  logic                         clock,
    input  logic                         reset,
    input  dcache_pkg::dcache_request_t  active_req,
    output logic                         hit,
    output dcache_pkg::block_t           hit_block,
    input  logic [$clog2(num_lines)-1:0] victim_index,
    output logic                         victim_valid,
    output logic                         victim_dirty,
    output dcache_pkg::addr_t            victim_addr,
    output dcache_pkg::block_t           victim_block,
    input  logic                         fill_valid,
    input  dcache_pkg::addr_t            fill_addr,
    input  dcache_pkg::block_t           fill_block,
    input  logic                         clean_valid
);
    import dcache_pkg::*;

    localparam int index_bits = $clog2(num_lines);
    localparam int tag_bits   = 32 - index_bits - BLOCK_OFFSET_BITS;

    typedef logic [index_bits-1:0]        index_t;
    typedef logic [tag_bits-1:0]          tag_t;
    typedef logic [BLOCK_OFFSET_BITS-1:0] offset_t;

    logic [num_lines-1:0] valid_q;
    logic [num_lines-1:0] dirty_q;
    tag_t                 tag_q  [num_lines];
    block_t               data_q [num_lines];

    index_t  req_index;
    tag_t    req_tag;
    offset_t req_offset;
    index_t  fill_index;
    tag_t    fill_tag;
    logic    store_hit;
    block_t  merged_block;

    // drop the store data into its byte lanes, halves and words stay aligned
    function automatic block_t merge_store(block_t old_block, mem_size_e size,
                                           offset_t offset, word_t data);
        block_t result;
        result = old_block;
        case (size)
            BYTE:    result[offset*8 +: 8]          = data[7:0];
            HALF:    result[offset[2:1]*16 +: 16]   = data[15:0];
            default: result[offset[2]*32 +: 32]     = data;
        endcase
        return result;
    endfunction

    // address split: tag | index | offset
    assign req_offset = active_req.addr[BLOCK_OFFSET_BITS-1:0];
    assign req_index  = active_req.addr[BLOCK_OFFSET_BITS +: index_bits];
    assign req_tag    = active_req.addr[31 -: tag_bits];

    assign fill_index = fill_addr[BLOCK_OFFSET_BITS +: index_bits];
    assign fill_tag   = fill_addr[31 -: tag_bits];

    assign hit       = active_req.valid & valid_q[req_index] & (tag_q[req_index] == req_tag);
    assign hit_block = data_q[req_index];
    assign store_hit = hit & (active_req.mem_op == MEM_WRITE);

    assign merged_block = merge_store(data_q[req_index], active_req.size, req_offset,
                                      active_req.write_content);

    // victim readout, address rebuilt from the stored tag
    assign victim_valid = valid_q[victim_index];
    assign victim_dirty = dirty_q[victim_index];
    assign victim_addr  = {tag_q[victim_index], victim_index, {BLOCK_OFFSET_BITS{1'b0}}};
    assign victim_block = data_q[victim_index];

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (fill_valid) begin
                valid_q[fill_index] <= 1'b1;
                dirty_q[fill_index] <= 1'b0;   // freshly filled lines are clean
            end
            if (clean_valid) dirty_q[victim_index] <= 1'b0;
            if (store_hit) dirty_q[req_index] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (fill_valid) begin
            tag_q[fill_index]  <= fill_tag;
            data_q[fill_index] <= fill_block;
        end
        if (store_hit) data_q[req_index] <= merged_block;
    end

endmodule

// ==== rtl/dcache_load_align.sv ====
`timescale 1ns/1ns

module dcache_load_align (
    input  logic                          clock,
    input  logic                          reset,
    input  dcache_pkg::dcache_request_t   active_req,
    input  logic                          hit,
    input  dcache_pkg::block_t            hit_block,
    output dcache_pkg::dcache_response_t  dcache_response
);
    import dcache_pkg::*;

    logic [BLOCK_OFFSET_BITS-1:0] offset;
    word_t                        load_data;

    assign offset = active_req.addr[BLOCK_OFFSET_BITS-1:0];

    // pick the addressed lane and zero extend, stores answer with zero
    always_comb begin
        load_data = '0;
        if (active_req.mem_op == MEM_READ) begin
            case (active_req.size)
                BYTE:    load_data[7:0]  = hit_block[offset*8 +: 8];
                HALF:    load_data[15:0] = hit_block[offset[2:1]*16 +: 16];
                default: load_data       = hit_block[offset[2]*32 +: 32];
            endcase
        end
    end

    always_ff @(posedge clock) begin
        dcache_response.reg_data <= load_data;
        if (reset) begin
            dcache_response.valid <= 1'b0;
        end else begin
            dcache_response.valid <= active_req.valid & hit;   // one pulse per hit
        end
    end

endmodule

// ==== rtl/dcache_miss_ctrl.sv ====
`timescale 1ns/1ns

module dcache_miss_ctrl #(
    parameter int num_lines = 8
) (
    input  logic                         clock,
    input  logic                         reset,
    input  dcache_pkg::dcache_request_t  dcache_request,
    output logic                         stall,
    output dcache_pkg::dcache_request_t  active_req,
    input  logic                         hit,
    input  logic                         victim_valid,
    input  logic                         victim_dirty,
    input  dcache_pkg::addr_t            victim_addr,
    input  dcache_pkg::block_t           victim_block,
    output logic [$clog2(num_lines)-1:0] victim_index,
    output logic                         fill_valid,
    output dcache_pkg::addr_t            fill_addr,
    output dcache_pkg::block_t           fill_block,
    output logic                         clean_valid,
    input  dcache_pkg::mem_tag_t         mem_response,
    input  dcache_pkg::block_t           mem_data,
    input  dcache_pkg::mem_tag_t         mem_tag,
    output dcache_pkg::mem_bus_req_t     mem_req,
    input  logic                         done,
    output logic                         flush_finished
);
    import dcache_pkg::*;

    localparam int index_bits = $clog2(num_lines);

    typedef logic [index_bits-1:0] index_t;

    typedef enum logic [2:0] {
        READY,
        WRITEBACK,
        FILL_ISSUE,
        FILL_WAIT,
        REPLAY,
        FLUSH_SCAN,
        FLUSH_WRITE,
        FLUSHED
    } miss_state_e;

    miss_state_e     state;
    miss_state_e     next_state;
    dcache_request_t held_req;           // the missed request, replayed after the fill
    mem_tag_t        wait_tag;           // tag of the outstanding line load
    index_t          flush_index;
    index_t          next_flush_index;
    logic            mem_accepted;
    logic            victim_needs_store;
    logic            last_index;
    logic            capture_miss;
    addr_t           held_line_addr;

    assign mem_accepted       = (mem_response != '0);
    assign victim_needs_store = victim_valid & victim_dirty;
    assign last_index         = (flush_index == index_t'(num_lines - 1));
    assign capture_miss       = (state == READY) & dcache_request.valid & ~hit;
    assign held_line_addr     = {held_req.addr[31:BLOCK_OFFSET_BITS], {BLOCK_OFFSET_BITS{1'b0}}};

    assign stall          = (state != READY);
    assign flush_finished = (state == FLUSHED);

    // only READY and REPLAY touch the array on behalf of the pipeline
    always_comb begin
        case (state)
            READY:   active_req = dcache_request.valid ? dcache_request : '0;
            REPLAY:  active_req = held_req;
            default: active_req = '0;
        endcase
    end

    always_comb begin
        if (state == FLUSH_SCAN || state == FLUSH_WRITE) begin
            victim_index = flush_index;
        end else if (state == READY) begin
            victim_index = dcache_request.addr[BLOCK_OFFSET_BITS +: index_bits];
        end else begin
            victim_index = held_req.addr[BLOCK_OFFSET_BITS +: index_bits];
        end
    end

    always_comb begin
        next_state       = state;
        next_flush_index = flush_index;
        mem_req          = '0;
        mem_req.command  = BUS_NONE;
        fill_valid       = 1'b0;
        fill_addr        = held_line_addr;
        fill_block       = mem_data;
        clean_valid      = 1'b0;
        case (state)
            READY: begin
                if (capture_miss) begin
                    next_state = victim_needs_store ? WRITEBACK : FILL_ISSUE;
                end else if (done) begin
                    next_state       = FLUSH_SCAN;
                    next_flush_index = '0;
                end
            end
            WRITEBACK: begin
                mem_req.command = BUS_STORE;
                mem_req.addr    = victim_addr;
                mem_req.data    = victim_block;
                if (mem_accepted) begin
                    clean_valid = 1'b1;   // store is done once accepted
                    next_state  = FILL_ISSUE;
                end
            end
            FILL_ISSUE: begin
                mem_req.command = BUS_LOAD;
                mem_req.addr    = held_line_addr;
                if (mem_accepted) next_state = FILL_WAIT;
            end
            FILL_WAIT: begin
                if (mem_tag == wait_tag) begin
                    fill_valid = 1'b1;
                    next_state = REPLAY;
                end
            end
            REPLAY: begin
                next_state = READY;   // line is in place, the hit path answers
            end
            FLUSH_SCAN: begin
                if (victim_needs_store) begin
                    next_state = FLUSH_WRITE;
                end else if (last_index) begin
                    next_state = FLUSHED;
                end else begin
                    next_flush_index = index_t'(flush_index + 1'b1);
                end
            end
            FLUSH_WRITE: begin
                mem_req.command = BUS_STORE;
                mem_req.addr    = victim_addr;
                mem_req.data    = victim_block;
                if (mem_accepted) begin
                    clean_valid = 1'b1;
                    if (last_index) begin
                        next_state = FLUSHED;
                    end else begin
                        next_state       = FLUSH_SCAN;
                        next_flush_index = index_t'(flush_index + 1'b1);
                    end
                end
            end
            FLUSHED: begin
                next_state = FLUSHED;   // parked until reset
            end
            default: begin
                next_state = READY;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state       <= READY;
            flush_index <= '0;
            wait_tag    <= '0;
        end else begin
            state       <= next_state;
            flush_index <= next_flush_index;
            if (state == FILL_ISSUE && mem_accepted) wait_tag <= mem_response;
        end
    end

    always_ff @(posedge clock) begin
        if (capture_miss) held_req <= dcache_request;
    end

endmodule

// ==== rtl/dcache_pkg.sv ====
package dcache_pkg;

    typedef logic [31:0] addr_t;     // byte address
    typedef logic [31:0] word_t;     // register data
    typedef logic [63:0] block_t;    // one cache line, word 0 in the low half
    typedef logic [3:0]  mem_tag_t;  // zero means no transaction

    // byte offset inside one line
    localparam int BLOCK_OFFSET_BITS = 3;

    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

    typedef enum logic [1:0] {
        BYTE = 2'h0,
        HALF = 2'h1,
        WORD = 2'h2
    } mem_size_e;

    typedef enum logic [1:0] {
        BUS_NONE  = 2'h0,
        BUS_LOAD  = 2'h1,
        BUS_STORE = 2'h2
    } bus_command_e;

    // pipeline to cache, held by the pipeline while stall is high
    typedef struct packed {
        logic      valid;
        mem_op_e   mem_op;
        mem_size_e size;
        addr_t     addr;
        word_t     write_content;
    } dcache_request_t;

    // cache to pipeline, valid for one cycle per accepted request
    typedef struct packed {
        logic  valid;
        word_t reg_data;   // zero for stores
    } dcache_response_t;

    // cache to memory, held until the memory returns a nonzero tag
    typedef struct packed {
        bus_command_e command;
        addr_t        addr;   // line aligned
        block_t       data;   // only meaningful for BUS_STORE
    } mem_bus_req_t;

endpackage

// ==== rtl/dcache_top.sv ====
`timescale 1ns/1ns

module dcache_top #(
    parameter int num_lines = 8
) (
    input  logic                          clock,
    input  logic                          reset,
    input  dcache_pkg::dcache_request_t   dcache_request,
    output dcache_pkg::dcache_response_t  dcache_response,
    output logic                          stall,
    input  dcache_pkg::mem_tag_t          mem_response,
    input  dcache_pkg::block_t            mem_data,
    input  dcache_pkg::mem_tag_t          mem_tag,
    output dcache_pkg::mem_bus_req_t      mem_req,
    input  logic                          done,
    output logic                          flush_finished
);
    import dcache_pkg::*;

    localparam int index_bits = $clog2(num_lines);

    dcache_request_t       active_req;   // request presented to the array this cycle
    logic                  hit;
    block_t                hit_block;
    logic [index_bits-1:0] victim_index;
    logic                  victim_valid;
    logic                  victim_dirty;
    addr_t                 victim_addr;
    block_t                victim_block;
    logic                  fill_valid;
    addr_t                 fill_addr;
    block_t                fill_block;
    logic                  clean_valid;

    dcache_line_array #(
        .num_lines    (num_lines)
    ) u_line_array (
        .clock        (clock),
        .reset        (reset),
        .active_req   (active_req),
        .hit          (hit),
        .hit_block    (hit_block),
        .victim_index (victim_index),
        .victim_valid (victim_valid),
        .victim_dirty (victim_dirty),
        .victim_addr  (victim_addr),
        .victim_block (victim_block),
        .fill_valid   (fill_valid),
        .fill_addr    (fill_addr),
        .fill_block   (fill_block),
        .clean_valid  (clean_valid)
    );

    dcache_miss_ctrl #(
        .num_lines      (num_lines)
    ) u_miss_ctrl (
        .clock          (clock),
        .reset          (reset),
        .dcache_request (dcache_request),
        .stall          (stall),
        .active_req     (active_req),
        .hit            (hit),
        .victim_valid   (victim_valid),
        .victim_dirty   (victim_dirty),
        .victim_addr    (victim_addr),
        .victim_block   (victim_block),
        .victim_index   (victim_index),
        .fill_valid     (fill_valid),
        .fill_addr      (fill_addr),
        .fill_block     (fill_block),
        .clean_valid    (clean_valid),
        .mem_response   (mem_response),
        .mem_data       (mem_data),
        .mem_tag        (mem_tag),
        .mem_req        (mem_req),
        .done           (done),
        .flush_finished (flush_finished)
    );

    dcache_load_align u_load_align (
        .clock           (clock),
        .reset           (reset),
        .active_req      (active_req),
        .hit             (hit),
        .hit_block       (hit_block),
        .dcache_response (dcache_response)
    );

endmodule

// ==== src.f ====
rtl/dcache_pkg.sv
rtl/dcache_line_array.sv
rtl/dcache_miss_ctrl.sv
rtl/dcache_load_align.sv
rtl/dcache_top.sv
verif/dcache_mem_model.sv
verif/dcache_tb.sv

// ==== verif/dcache_mem_model.sv ====
`timescale 1ns/1ns

module dcache_mem_model #(
    parameter int latency = 3
) (
    input  logic                      clock,
    input  logic                      reset,
    input  dcache_pkg::mem_bus_req_t  mem_req,
    output dcache_pkg::mem_tag_t      mem_response,
    output dcache_pkg::block_t        mem_data,
    output dcache_pkg::mem_tag_t      mem_tag
);
    import dcache_pkg::*;

    block_t   backing [addr_t];          // lines stored so far
    addr_t    store_addr_log [0:1023];
    block_t   store_data_log [0:1023];
    int       store_count;
    mem_tag_t next_tag;
    logic     load_pending;
    mem_tag_t load_tag;
    block_t   load_block;
    int       load_delay;

    // untouched lines read as their own word addresses xor a key
    function automatic block_t read_line(addr_t line_addr);
        if (backing.exists(line_addr)) return backing[line_addr];
        return {(line_addr + 32'd4) ^ 32'h5a5a0000, line_addr ^ 32'h5a5a0000};
    endfunction

    // every command is taken in the cycle it shows up
    assign mem_response = (mem_req.command != BUS_NONE) ? next_tag : '0;

    initial begin
        mem_tag  = '0;
        mem_data = '0;
    end

    always @(posedge clock) begin
        if (reset) begin
            next_tag     <= 4'd1;
            load_pending <= 1'b0;
            load_delay   <= 0;
            mem_tag      <= '0;
            store_count  <= 0;
        end else begin
            mem_tag <= '0;   // tag is shown for one cycle only
            if (load_pending) begin
                if (load_delay == 0) begin
                    mem_tag      <= load_tag;
                    mem_data     <= load_block;
                    load_pending <= 1'b0;
                end else begin
                    load_delay <= load_delay - 1;
                end
            end
            if (mem_req.command != BUS_NONE) begin
                next_tag <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
                if (mem_req.command == BUS_STORE) begin
                    backing[mem_req.addr] = mem_req.data;
                    store_addr_log[store_count] <= mem_req.addr;
                    store_data_log[store_count] <= mem_req.data;
                    store_count <= store_count + 1;
                end else begin
                    load_pending <= 1'b1;
                    load_tag     <= next_tag;
                    load_block   <= read_line(mem_req.addr);
                    load_delay   <= latency - 1;
                end
            end
        end
    end

endmodule

// ==== verif/dcache_tb.sv ====
`timescale 1ns/1ns

module dcache_tb;
    import dcache_pkg::*;

    localparam int    num_lines       = 8;
    localparam int    index_bits      = $clog2(num_lines);
    localparam int    clock_period    = 100;
    localparam int    test_requests   = 1 + 2 + 10 + 3 + 200 + 8;   // summed test lengths
    localparam int    watchdog_cycles = test_requests * 200;
    localparam word_t pattern_key     = 32'h5a5a0000;

    logic             clock;
    logic             reset;
    dcache_request_t  dcache_request;
    dcache_response_t dcache_response;
    logic             stall;
    mem_tag_t         mem_response;
    block_t           mem_data;
    mem_tag_t         mem_tag;
    mem_bus_req_t     mem_req;
    logic             done;
    logic             flush_finished;

    logic [7:0]  shadow [addr_t];     // bytes stored by the tests
    logic        cached_valid [num_lines];
    logic        cached_dirty [num_lines];
    addr_t       cached_line  [num_lines];
    logic        touched [addr_t];
    addr_t       touched_lines [$];
    logic [31:0] lcg_state;
    int          error_count;
    int          check_count;
    int          expected_stores;

    dcache_top #(
        .num_lines       (num_lines)
    ) u_dut (
        .clock           (clock),
        .reset           (reset),
        .dcache_request  (dcache_request),
        .dcache_response (dcache_response),
        .stall           (stall),
        .mem_response    (mem_response),
        .mem_data        (mem_data),
        .mem_tag         (mem_tag),
        .mem_req         (mem_req),
        .done            (done),
        .flush_finished  (flush_finished)
    );

    dcache_mem_model u_mem (
        .clock        (clock),
        .reset        (reset),
        .mem_req      (mem_req),
        .mem_response (mem_response),
        .mem_data     (mem_data),
        .mem_tag      (mem_tag)
    );

    always #(clock_period / 2) clock = ~clock;

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [7:0] shadow_byte(addr_t addr);
        word_t pattern;
        if (shadow.exists(addr)) return shadow[addr];
        pattern = {addr[31:2], 2'b00} ^ pattern_key;
        return pattern[addr[1:0]*8 +: 8];
    endfunction

    function automatic block_t shadow_line(addr_t line);
        block_t result;
        for (int i = 0; i < 8; i++) result[i*8 +: 8] = shadow_byte(line + i);
        return result;
    endfunction

    function automatic int size_bytes(mem_size_e size);
        return (size == BYTE) ? 1 : (size == HALF) ? 2 : 4;
    endfunction

    task automatic check(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
        check_count++;
        if (actual !== expected) begin
            $display("Fail %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int start_errors);
        $display("test %s finished with %0d errors", name, error_count - start_errors);
    endtask

    // drives one request from a falling edge and holds it until its response
    task automatic access(input mem_op_e op, input mem_size_e size, input addr_t addr,
                          input word_t data, output word_t result, output int latency);
        int              index;
        addr_t           line;
        logic            evict;
        addr_t           victim;
        block_t          victim_data;
        word_t           expected;
        dcache_request_t request;
        index    = int'(addr[3 +: index_bits]);
        line     = {addr[31:3], 3'b000};
        evict    = 1'b0;
        expected = '0;
        if (!(cached_valid[index] && cached_line[index] == line)) begin
            evict       = cached_valid[index] & cached_dirty[index];   // dirty victim goes back
            victim      = cached_line[index];
            victim_data = shadow_line(victim);
            cached_valid[index] = 1'b1;
            cached_dirty[index] = 1'b0;
            cached_line[index]  = line;
        end
        for (int i = 0; i < size_bytes(size); i++) begin
            if (op == MEM_READ) begin
                expected[i*8 +: 8] = shadow_byte(addr + i);
            end else begin
                shadow[addr + i] = data[i*8 +: 8];
            end
        end
        if (op == MEM_WRITE) begin
            cached_dirty[index] = 1'b1;
            if (!touched.exists(line)) begin
                touched[line] = 1'b1;
                touched_lines.push_back(line);
            end
        end
        while (stall) @(negedge clock);
        request.valid         = 1'b1;
        request.mem_op        = op;
        request.size          = size;
        request.addr          = addr;
        request.write_content = data;
        dcache_request = request;
        latency = 0;
        do begin
            @(negedge clock);
            latency++;
            // stall covers the whole miss and drops with the response
            if (dcache_response.valid) begin
                check("stall", stall, 1'b0);
            end else begin
                check("stall", stall, 1'b1);
            end
        end while (!dcache_response.valid && latency < 200);
        dcache_request = '0;
        result = dcache_response.reg_data;
        if (!dcache_response.valid) begin
            $display("no response from the cache for the access at address 0x%h", addr);
            error_count++;
        end
        check("reg_data", result, expected);
        if (evict) begin
            expected_stores++;
            check("writeback addr", u_mem.store_addr_log[expected_stores-1], victim);
            check("writeback data", u_mem.store_data_log[expected_stores-1], victim_data);
        end
        check("store_count", u_mem.store_count, expected_stores);
    endtask

    task automatic reset_outputs();
        int start;
        start = error_count;
        check("stall", stall, 1'b0);
        check("response valid", dcache_response.valid, 1'b0);
        check("mem command", mem_req.command, BUS_NONE);
        check("flush_finished", flush_finished, 1'b0);
        report_test("reset state", start);
    endtask

    task automatic miss_then_hit();
        int    start;
        word_t result;
        int    latency;
        start = error_count;
        access(MEM_READ, WORD, 32'h0000_0100, '0, result, latency);
        check("miss latency above one", latency > 1, 1'b1);
        access(MEM_READ, WORD, 32'h0000_0104, '0, result, latency);
        check("hit latency", latency, 1);
        check("stall on hit", stall, 1'b0);
        report_test("load miss then hit", start);
    endtask

    task automatic sized_access();
        int    start;
        word_t result;
        int    latency;
        start = error_count;
        access(MEM_WRITE, BYTE, 32'h0000_0209, 32'hffff_ffa5, result, latency);
        access(MEM_WRITE, HALF, 32'h0000_020a, 32'hbeef_1234, result, latency);
        access(MEM_WRITE, WORD, 32'h0000_020c, 32'hdead_beef, result, latency);
        access(MEM_READ, BYTE, 32'h0000_0209, '0, result, latency);
        access(MEM_READ, BYTE, 32'h0000_020b, '0, result, latency);
        access(MEM_READ, HALF, 32'h0000_020a, '0, result, latency);
        access(MEM_READ, HALF, 32'h0000_0208, '0, result, latency);
        access(MEM_READ, WORD, 32'h0000_0208, '0, result, latency);
        access(MEM_READ, WORD, 32'h0000_020c, '0, result, latency);
        access(MEM_READ, BYTE, 32'h0000_020f, '0, result, latency);
        report_test("sized stores and loads", start);
    endtask

    task automatic conflict_eviction();
        int    start;
        int    start_count;
        addr_t line_a;
        addr_t line_b;
        word_t result;
        int    latency;
        start  = error_count;
        line_a = 32'h0000_0300;
        line_b = line_a + num_lines * 8;   // same index with another tag
        access(MEM_WRITE, WORD, line_a + 4, 32'h1357_9bdf, result, latency);
        start_count = u_mem.store_count;
        access(MEM_READ, WORD, line_b, '0, result, latency);
        check("dirty eviction stores", u_mem.store_count - start_count, 1);
        check("evicted addr", u_mem.store_addr_log[start_count], line_a);
        check("evicted data", u_mem.store_data_log[start_count], shadow_line(line_a));
        start_count = u_mem.store_count;
        access(MEM_READ, HALF, line_a + 2, '0, result, latency);
        check("clean eviction stores", u_mem.store_count - start_count, 0);
        report_test("conflict eviction", start);
    endtask

    task automatic random_traffic();
        int          start;
        logic [31:0] rnd;
        addr_t       addr;
        mem_size_e   size;
        mem_op_e     op;
        word_t       result;
        int          latency;
        start = error_count;
        for (int n = 0; n < 200; n++) begin
            rnd  = next_random();
            addr = 32'h0000_1000 + rnd[7:0];   // 32 lines over 8 slots
            size = mem_size_e'(rnd[9:8] % 3);
            if (size == HALF) addr[0] = 1'b0;
            if (size == WORD) addr[1:0] = 2'b00;
            op = rnd[10] ? MEM_WRITE : MEM_READ;
            access(op, size, addr, next_random(), result, latency);
        end
        report_test("random traffic", start);
    endtask

    task automatic flush_dirty_lines();
        int    start;
        int    dirty_lines;
        int    start_count;
        int    waited;
        word_t result;
        int    latency;
        start = error_count;
        access(MEM_WRITE, BYTE, 32'h0000_2001, 32'h0000_005c, result, latency);
        access(MEM_WRITE, HALF, 32'h0000_2012, 32'h0000_7e11, result, latency);
        access(MEM_WRITE, WORD, 32'h0000_2038, 32'h0bad_f00d, result, latency);
        dirty_lines = 0;
        for (int i = 0; i < num_lines; i++) begin
            if (cached_valid[i] && cached_dirty[i]) dirty_lines++;
        end
        start_count = u_mem.store_count;
        done   = 1'b1;
        waited = 0;
        while (!flush_finished && waited < 40 * num_lines) begin
            @(negedge clock);
            waited++;
            check("stall during flush", stall, 1'b1);
        end
        if (!flush_finished) begin
            $display("flush did not finish within %0d cycles", waited);
            error_count++;
        end
        check("flush stores", u_mem.store_count - start_count, dirty_lines);
        @(negedge clock);
        check("flush_finished held", flush_finished, 1'b1);
        for (int i = 0; i < touched_lines.size(); i++) begin
            check("backing line", u_mem.read_line(touched_lines[i]),
                  shadow_line(touched_lines[i]));
        end
        report_test("flush", start);
    endtask

    initial begin
        clock           = 1'b0;
        reset           = 1'b1;
        dcache_request  = '0;
        done            = 1'b0;
        error_count     = 0;
        check_count     = 0;
        expected_stores = 0;
        lcg_state       = 32'hf809;
        for (int i = 0; i < num_lines; i++) begin
            cached_valid[i] = 1'b0;
            cached_dirty[i] = 1'b0;
            cached_line[i]  = '0;
        end
        repeat (8) @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        reset_outputs();
        miss_then_hit();
        sized_access();
        conflict_eviction();
        random_traffic();
        flush_dirty_lines();   // the cache stays parked after the flush
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(watchdog_cycles * clock_period);
        $display("watchdog expired after %0d cycles, the cache stopped answering",
                 watchdog_cycles);
        $display("Test failed");
        $finish;
    end

endmodule
